//--- circular_queue.sv
`timescale 1ns/1ns

module circular_queue #(
    parameter int DEPTH         = 4,
    parameter int DATA_W        = 32,
    parameter bit FILL_ON_RESET = 1'b0,
    parameter int FILL_BASE     = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  logic [DATA_W-1:0] in,
    input  logic              pop,
    output logic [DATA_W-1:0] out,
    output logic              full,
    output logic              empty
);
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int HALF_W = DATA_W / 2;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Free list variant starts out holding register pairs
    always_ff @(posedge clk) begin
        if (reset && FILL_ON_RESET) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i][DATA_W-1 -: HALF_W] <= HALF_W'(FILL_BASE + 2 * i);
                mem[i][HALF_W-1:0]         <= HALF_W'(FILL_BASE + 2 * i + 1);
            end
        end else if (do_push) begin
            mem[tail] <= in;
        end
    end

    // Pointers; a filled queue has wrapped so tail meets head at 0
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= FILL_ON_RESET ? CNT_W'(DEPTH) : '0;
        end else begin
            if (do_push) begin
                tail <= next_ptr(tail);
            end
            if (do_pop) begin
                head <= next_ptr(head);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Oldest entry always visible
    assign out   = mem[head];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    no_push_full: assert property (@(posedge clk) disable iff (reset) full |-> !push);
    no_pop_empty: assert property (@(posedge clk) disable iff (reset) empty |-> !pop);
endmodule

//--- cpu.sv
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module cpu (
    input  logic                 clk,
    input  logic                 reset,

    output logic [31:0]          imem_addr,
    output logic [3:0]           imem_rmask,
    input  logic [31:0]          imem_rdata,
    input  logic                 imem_resp,

    output logic                 disp_valid,
    input  logic                 disp_ready,
    output logic [31:0]          disp_pc        [`SS],
    output rv32i_types::opcode_t disp_opcode    [`SS],
    output logic [`PREG_W-1:0]   disp_prd       [`SS],
    output logic [`PREG_W-1:0]   disp_prs1      [`SS],
    output logic [`PREG_W-1:0]   disp_prs2      [`SS],
    output logic [`PREG_W-1:0]   disp_stale_prd [`SS],

    input  logic                 retire_valid,
    input  logic [`PREG_W-1:0]   retire_preg    [`SS]
);
    import rv32i_types::*;

    localparam int INST_W = $bits(decoded_inst_t);
    localparam int PW     = `PREG_W;

    logic                  fetch_req;
    logic [31:0]           fetch_pc;
    logic                  accept;
    logic                  iq_full;
    logic                  iq_empty;
    logic                  pair_valid;
    logic                  pop_pair;
    logic                  fl_empty;
    logic [`SS*INST_W-1:0] iq_in;
    logic [`SS*INST_W-1:0] iq_out;
    logic [2*PW-1:0]       fl_head;
    decoded_inst_t         decoded_inst;
    decoded_inst_t         pair_inst [`SS];
    decoded_inst_t         iq_head   [`SS];
    dispatch_t             disp      [`SS];

    rat_if rat_bus ();

    // Fetch stalls on a full queue so no pair is dropped
    fetch_stage fetch_stage_i (
        .clk       (clk),
        .reset     (reset),
        .stall     (iq_full),
        .imem_resp (imem_resp),
        .fetch_pc  (fetch_pc),
        .fetch_req (fetch_req)
    );

    assign imem_addr  = fetch_pc;
    assign imem_rmask = {4{fetch_req}};
    // Word decoded in its response cycle
    assign accept     = fetch_req & imem_resp;

    id_stage id_stage_i (
        .fetch_pc         (fetch_pc),
        .imem_rdata       (imem_rdata),
        .instruction_info (decoded_inst)
    );

    two_inst_buff buff (
        .clk          (clk),
        .reset        (reset),
        .valid        (accept),
        .decoded_inst (decoded_inst),
        .valid_inst   (pair_inst),
        .valid_out    (pair_valid)
    );

    // Pairs flattened for the generic queue, dispatch fields split out
    for (genvar s = 0; s < `SS; s++) begin : g_slot
        assign iq_in[s*INST_W +: INST_W] = pair_inst[s];
        assign iq_head[s]                = decoded_inst_t'(iq_out[s*INST_W +: INST_W]);
        assign disp_pc[s]                = disp[s].pc;
        assign disp_opcode[s]            = disp[s].opcode;
        assign disp_prd[s]               = disp[s].prd;
        assign disp_prs1[s]              = disp[s].prs1;
        assign disp_prs2[s]              = disp[s].prs2;
        assign disp_stale_prd[s]         = disp[s].stale_prd;
    end

    circular_queue #(
        .DEPTH         (`IQ_DEPTH),
        .DATA_W        (`SS * INST_W),
        .FILL_ON_RESET (1'b0),
        .FILL_BASE     (0)
    ) instruction_queue (
        .clk   (clk),
        .reset (reset),
        .push  (pair_valid),
        .in    (iq_in),
        .pop   (pop_pair),
        .out   (iq_out),
        .full  (iq_full),
        .empty (iq_empty)
    );

    // Registers above the architectural 32 start free
    circular_queue #(
        .DEPTH         (`FL_DEPTH),
        .DATA_W        (2 * PW),
        .FILL_ON_RESET (1'b1),
        .FILL_BASE     (`NUM_PREGS - 2 * `FL_DEPTH)
    ) free_list (
        .clk   (clk),
        .reset (reset),
        .push  (retire_valid),
        .in    ({retire_preg[0], retire_preg[1]}),
        .pop   (pop_pair),
        .out   (fl_head),
        .full  (),
        .empty (fl_empty)
    );

    rat rat_i (
        .clk      (clk),
        .reset    (reset),
        .rat_port (rat_bus.map_table)
    );

    rename_dispatch rename_i (
        .clk            (clk),
        .reset          (reset),
        .instruction    (iq_head),
        .inst_q_empty   (iq_empty),
        .free_list_regs (fl_head),
        .fl_empty       (fl_empty),
        .disp_ready     (disp_ready),
        .rat_port       (rat_bus.renamer),
        .disp_valid     (disp_valid),
        .disp           (disp),
        .pop_inst_q     (pop_pair)
    );
endmodule

//--- fetch_stage.sv
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module fetch_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        imem_resp,
    output logic [31:0] fetch_pc,
    output logic        fetch_req
);
    logic req_en;
    logic accept;

    // Request stays low through the reset cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            req_en <= 1'b0;
        end else begin
            req_en <= 1'b1;
        end
    end

    // Drop the request while the instruction queue is full
    assign fetch_req = req_en & ~stall;
    // Response only counts while the request is open
    assign accept = fetch_req & imem_resp;

    // PC holds until its word is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= `RESET_PC;
        end else if (accept) begin
            fetch_pc <= fetch_pc + 32'd4;
        end
    end

    // Word steps only, from reset onwards
    pc_aligned: assert property (@(posedge clk) disable iff (reset) fetch_pc[1:0] == 2'b00);
endmodule

//--- id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic [31:0]                fetch_pc,
    input  logic [31:0]                imem_rdata,
    output rv32i_types::decoded_inst_t instruction_info
);
    import rv32i_types::*;

    opcode_t op;
    logic    use_rd;
    logic    use_rs1;
    logic    use_rs2;

    // Major opcode to instruction class
    always_comb begin
        case (imem_rdata[6:0])
            7'b0110111: op = op_lui;
            7'b0010111: op = op_auipc;
            7'b1101111: op = op_jal;
            7'b1100111: op = op_jalr;
            7'b1100011: op = op_br;
            7'b0000011: op = op_load;
            7'b0100011: op = op_store;
            7'b0010011: op = op_imm;
            7'b0110011: op = op_reg;
            default:    op = op_bad;
        endcase
    end

    // Branch and store write no register
    assign use_rd  = (op != op_br) && (op != op_store);
    // U and J formats carry no rs1
    assign use_rs1 = (op != op_lui) && (op != op_auipc) && (op != op_jal);
    // Only B, S and R formats read rs2
    assign use_rs2 = (op == op_br) || (op == op_store) || (op == op_reg);

    always_comb begin
        instruction_info.pc     = fetch_pc;
        instruction_info.opcode = op;
        // Unused fields forced to x0 so rename sees no false dependency
        instruction_info.rd     = use_rd  ? imem_rdata[11:7]  : 5'd0;
        instruction_info.rs1    = use_rs1 ? imem_rdata[19:15] : 5'd0;
        instruction_info.rs2    = use_rs2 ? imem_rdata[24:20] : 5'd0;
    end
endmodule

//--- rat.sv
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module rat (
    input logic      clk,
    input logic      reset,
    rat_if.map_table rat_port
);
    localparam int PW = `PREG_W;

    logic [PW-1:0] map [32];

    // Lookups are combinational, one set per slot
    always_comb begin
        for (int s = 0; s < `SS; s++) begin
            rat_port.map_rs1[s] = map[rat_port.isa_rs1[s]];
            rat_port.map_rs2[s] = map[rat_port.isa_rs2[s]];
            rat_port.map_rd[s]  = map[rat_port.isa_rd[s]];
        end
    end

    // Identity at reset, x0 stays on physical 0
    // Later slot applied last so it wins on a shared rd
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                map[r] <= PW'(r);
            end
        end else if (rat_port.we) begin
            for (int s = 0; s < `SS; s++) begin
                if (rat_port.isa_rd[s] != 5'd0) begin
                    map[rat_port.isa_rd[s]] <= rat_port.new_prd[s];
                end
            end
        end
    end
endmodule

//--- rat_if.sv
`timescale 1ns/1ns
`include "rv32i_defines.svh"

interface rat_if;
    // Source lookups per slot
    logic [4:0]         isa_rs1 [`SS];
    logic [4:0]         isa_rs2 [`SS];
    logic [`PREG_W-1:0] map_rs1 [`SS];
    logic [`PREG_W-1:0] map_rs2 [`SS];
    // Destination lookup, current mapping comes back as map_rd
    logic [4:0]         isa_rd  [`SS];
    logic [`PREG_W-1:0] map_rd  [`SS];
    // New destination mapping, written when we is high
    logic [`PREG_W-1:0] new_prd [`SS];
    logic               we;

    modport renamer (
        output isa_rs1, isa_rs2, isa_rd, new_prd, we,
        input  map_rs1, map_rs2, map_rd
    );

    modport map_table (
        input  isa_rs1, isa_rs2, isa_rd, new_prd, we,
        output map_rs1, map_rs2, map_rd
    );
endinterface

//--- rename_dispatch.sv
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module rename_dispatch (
    input  logic                       clk,
    input  logic                       reset,
    input  rv32i_types::decoded_inst_t instruction [`SS],
    input  logic                       inst_q_empty,
    input  logic [2*`PREG_W-1:0]       free_list_regs,
    input  logic                       fl_empty,
    input  logic                       disp_ready,
    rat_if.renamer                     rat_port,
    output logic                       disp_valid,
    output rv32i_types::dispatch_t     disp [`SS],
    output logic                       pop_inst_q
);
    localparam int PW = `PREG_W;

    logic [PW-1:0] alloc [`SS];
    logic          fwd_rs1;
    logic          fwd_rs2;
    logic          fwd_rd;

    // Slot 0 gets the upper half of the free pair
    assign alloc[0] = free_list_regs[2*PW-1:PW];
    assign alloc[1] = free_list_regs[PW-1:0];

    // Need both an instruction pair and a register pair
    assign disp_valid = ~inst_q_empty & ~fl_empty;
    assign pop_inst_q = disp_valid & disp_ready;

    // Table lookups for the head pair
    always_comb begin
        for (int s = 0; s < `SS; s++) begin
            rat_port.isa_rs1[s] = instruction[s].rs1;
            rat_port.isa_rs2[s] = instruction[s].rs2;
            rat_port.isa_rd[s]  = instruction[s].rd;
            rat_port.new_prd[s] = alloc[s];
        end
    end
    // Table and both queues move together on the handshake
    assign rat_port.we = pop_inst_q;

    // Slot 1 depends on slot 0 only through a real rd
    assign fwd_rs1 = (instruction[0].rd != 5'd0) && (instruction[1].rs1 == instruction[0].rd);
    assign fwd_rs2 = (instruction[0].rd != 5'd0) && (instruction[1].rs2 == instruction[0].rd);
    assign fwd_rd  = (instruction[0].rd != 5'd0) && (instruction[1].rd == instruction[0].rd);

    always_comb begin
        disp[0].pc        = instruction[0].pc;
        disp[0].opcode    = instruction[0].opcode;
        disp[0].prd       = alloc[0];
        disp[0].prs1      = (instruction[0].rs1 == 5'd0) ? '0 : rat_port.map_rs1[0];
        disp[0].prs2      = (instruction[0].rs2 == 5'd0) ? '0 : rat_port.map_rs2[0];
        // x0 target hands its own register back on retire
        disp[0].stale_prd = (instruction[0].rd == 5'd0) ? alloc[0] : rat_port.map_rd[0];

        disp[1].pc        = instruction[1].pc;
        disp[1].opcode    = instruction[1].opcode;
        disp[1].prd       = alloc[1];
        // Slot 0 result not in the table yet so taken directly
        disp[1].prs1      = (instruction[1].rs1 == 5'd0) ? '0 :
                            fwd_rs1 ? alloc[0] : rat_port.map_rs1[1];
        disp[1].prs2      = (instruction[1].rs2 == 5'd0) ? '0 :
                            fwd_rs2 ? alloc[0] : rat_port.map_rs2[1];
        disp[1].stale_prd = (instruction[1].rd == 5'd0) ? alloc[1] :
                            fwd_rd ? alloc[0] : rat_port.map_rd[1];
    end

    // Free list never hands out physical 0 or one register twice
    alloc_valid: assert property (@(posedge clk) disable iff (reset)
        pop_inst_q |-> (alloc[0] != '0) && (alloc[1] != '0) && (alloc[0] != alloc[1]));
endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the front end and its testbench with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f sim.f -o tb_cpu \
    && ./obj_dir/tb_cpu 2>&1 | tee sim.log \
    || { echo "Verilator build or simulation run did not complete"; exit 1; }
# A missing log or a missing pass line also counts as failure
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

//--- rv32i_defines.svh
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// Instructions handled together as one pair
`define SS 2

// Physical register file size and index width
`define NUM_PREGS 64
`define PREG_W 6

// Queue depths in pairs
`define IQ_DEPTH 4
`define FL_DEPTH 16

// First fetch address
`define RESET_PC 32'h6000_0000

`endif

//--- rv32i_types.sv
`include "rv32i_defines.svh"

package rv32i_types;

    // Instruction class taken from the major opcode field
    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_br,
        op_load,
        op_store,
        op_imm,
        op_reg,
        op_bad
    } opcode_t;

    // One decoded instruction
    // Register fields the class does not use are zero
    typedef struct packed {
        logic [31:0] pc;
        opcode_t     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
    } decoded_inst_t;

    // Renamed instruction as it leaves the front end
    typedef struct packed {
        logic [31:0]        pc;
        opcode_t            opcode;
        logic [`PREG_W-1:0] prd;
        logic [`PREG_W-1:0] prs1;
        logic [`PREG_W-1:0] prs2;
        // Old mapping of rd, freed when this one retires
        logic [`PREG_W-1:0] stale_prd;
    } dispatch_t;

endpackage

//--- sim.f
+incdir+.
rv32i_types.sv
rat_if.sv
fetch_stage.sv
id_stage.sv
two_inst_buff.sv
circular_queue.sv
rat.sv
rename_dispatch.sv
cpu.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module tb_cpu;
    import rv32i_types::*;

    localparam int PW        = `PREG_W;
    localparam int MEM_WORDS = 256;
    localparam int SLOT_W    = 32 + $bits(opcode_t) + 4 * PW;
    // Major opcodes in opcode_t order
    localparam logic [6:0] MAJOR [9] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63,
                                        7'h03, 7'h23, 7'h13, 7'h33};

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic [31:0]            imem_addr;
    logic [3:0]             imem_rmask;
    logic [31:0]            imem_rdata = '0;
    logic                   imem_resp = 1'b0;
    logic                   disp_valid;
    logic                   disp_ready = 1'b0;
    logic [31:0]            disp_pc        [`SS];
    opcode_t                disp_opcode    [`SS];
    logic [PW-1:0]          disp_prd       [`SS];
    logic [PW-1:0]          disp_prs1      [`SS];
    logic [PW-1:0]          disp_prs2      [`SS];
    logic [PW-1:0]          disp_stale_prd [`SS];
    logic                   retire_valid = 1'b0;
    logic [PW-1:0]          retire_preg    [`SS] = '{default: '0};

    // Stimulus source and memory image
    logic [31:0]            lfsr = 32'h7e14_c2a9;
    logic [31:0]            mem_words [MEM_WORDS];
    int                     reset_cycles = 0;
    int                     wait_left = -1;
    bit                     retire_en = 1'b0;
    logic [2*PW-1:0]        retire_q [$];

    // Reference model state
    logic [PW-1:0]          mirror [32];
    logic [2*PW-1:0]        fl_model [$];
    logic [2*PW-1:0]        fl_head_exp;
    logic [31:0]            exp_pc;
    int                     disp_count;
    int                     retire_count;
    int                     words;
    int                     errors = 0;
    logic                   handshake;
    int                     fl_free;
    int                     iq_pairs;
    logic [`SS*SLOT_W-1:0]  disp_bus;
    logic [`SS*SLOT_W-1:0]  held_bus;

    // Expected values for the pair at the queue head
    logic [31:0]            exp_word  [`SS];
    opcode_t                exp_opc   [`SS];
    logic [4:0]             exp_rd    [`SS];
    logic [4:0]             exp_rs1   [`SS];
    logic [4:0]             exp_rs2   [`SS];
    logic [PW-1:0]          exp_prd   [`SS];
    logic [PW-1:0]          exp_prs1  [`SS];
    logic [PW-1:0]          exp_prs2  [`SS];
    logic [PW-1:0]          exp_stale [`SS];
    logic                   prd_mapped [`SS];

    cpu cpu_inst (.*);

    always #20 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] index;
        index = (addr - `RESET_PC) >> 2;
        return mem_words[index[7:0]];
    endfunction

    function automatic opcode_t class_of(input logic [31:0] w);
        opcode_t c;
        c = op_bad;
        for (int i = 0; i < 9; i++) begin
            if (w[6:0] == MAJOR[i]) begin
                c = opcode_t'(i);
            end
        end
        return c;
    endfunction

    // No rd for B/S, no rs1 for U/J, rs2 only for B/S/R
    function automatic logic [4:0] rd_of(input logic [31:0] w);
        opcode_t c;
        c = class_of(w);
        return (c == op_br || c == op_store) ? 5'd0 : w[11:7];
    endfunction

    function automatic logic [4:0] rs1_of(input logic [31:0] w);
        opcode_t c;
        c = class_of(w);
        return (c == op_lui || c == op_auipc || c == op_jal) ? 5'd0 : w[19:15];
    endfunction

    function automatic logic [4:0] rs2_of(input logic [31:0] w);
        opcode_t c;
        c = class_of(w);
        return (c == op_br || c == op_store || c == op_reg) ? w[24:20] : 5'd0;
    endfunction

    task automatic report_mismatch(input string what, input int slot,
                                   input logic [127:0] expected, input logic [127:0] actual);
        errors++;
        if (slot < 0) begin
            $display("[FAIL] %s: expected %0h, actual %0h", what, expected, actual);
        end else begin
            $display("[FAIL] %s slot %0d: expected %0h, actual %0h", what, slot, expected, actual);
        end
    endtask

    task automatic wait_for_pairs(input int target, input int limit, output bit ok);
        int n;
        n = 0;
        while (disp_count < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        ok = (disp_count >= target);
    endtask

    task automatic wait_for_stall(input int limit, output bit ok);
        int n;
        n = 0;
        while (imem_rmask != 4'h0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        ok = (imem_rmask == 4'h0);
    endtask

    assign handshake = disp_valid & disp_ready;
    assign fl_free   = `FL_DEPTH - disp_count + retire_count;
    assign iq_pairs  = words / 2 - disp_count;

    always_comb begin
        for (int s = 0; s < `SS; s++) begin
            disp_bus[s*SLOT_W +: SLOT_W] = {disp_pc[s], disp_opcode[s], disp_prd[s],
                                            disp_prs1[s], disp_prs2[s], disp_stale_prd[s]};
        end
    end

    always_comb begin
        for (int s = 0; s < `SS; s++) begin
            exp_word[s] = word_at(exp_pc + 32'(4 * s));
            exp_opc[s]  = class_of(exp_word[s]);
            exp_rd[s]   = rd_of(exp_word[s]);
            exp_rs1[s]  = rs1_of(exp_word[s]);
            exp_rs2[s]  = rs2_of(exp_word[s]);
            prd_mapped[s] = 1'b0;
            for (int r = 1; r < 32; r++) begin
                if (mirror[r] == disp_prd[s]) begin
                    prd_mapped[s] = 1'b1;
                end
            end
        end
        // Oldest free pair, first register to slot 0
        exp_prd[0]   = fl_head_exp[2*PW-1:PW];
        exp_prd[1]   = fl_head_exp[PW-1:0];
        // Slot 0 reads only the table
        exp_prs1[0]  = (exp_rs1[0] == 5'd0) ? '0 : mirror[exp_rs1[0]];
        exp_prs2[0]  = (exp_rs2[0] == 5'd0) ? '0 : mirror[exp_rs2[0]];
        exp_stale[0] = (exp_rd[0] == 5'd0) ? exp_prd[0] : mirror[exp_rd[0]];
        // Slot 1 sees slot 0's new register first
        exp_prs1[1]  = (exp_rs1[1] == 5'd0) ? '0 :
                       (exp_rs1[1] == exp_rd[0]) ? exp_prd[0] : mirror[exp_rs1[1]];
        exp_prs2[1]  = (exp_rs2[1] == 5'd0) ? '0 :
                       (exp_rs2[1] == exp_rd[0]) ? exp_prd[0] : mirror[exp_rs2[1]];
        exp_stale[1] = (exp_rd[1] == 5'd0) ? exp_prd[1] :
                       (exp_rd[1] == exp_rd[0]) ? exp_prd[0] : mirror[exp_rd[1]];
    end

    // Reference model advances on the same edges as the DUT
    always @(posedge clk) begin
        held_bus <= disp_bus;
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                mirror[r] <= PW'(r);
            end
            // Physical registers above the 32 architectural ones start free
            fl_model.delete();
            for (int i = 0; i < `FL_DEPTH; i++) begin
                fl_model.push_back({PW'(32 + 2 * i), PW'(32 + 2 * i + 1)});
            end
            fl_head_exp  <= fl_model[0];
            exp_pc       <= `RESET_PC;
            disp_count   <= 0;
            retire_count <= 0;
            words        <= 0;
            retire_q.delete();
        end else begin
            if (imem_rmask == 4'hf && imem_resp) begin
                words <= words + 1;
            end
            if (retire_valid) begin
                retire_count <= retire_count + 1;
                fl_model.push_back({retire_preg[0], retire_preg[1]});
            end
            if (handshake) begin
                // Slot 1 written last so it wins on a shared rd
                for (int s = 0; s < `SS; s++) begin
                    if (exp_rd[s] != 5'd0) begin
                        mirror[exp_rd[s]] <= exp_prd[s];
                    end
                end
                exp_pc     <= exp_pc + 32'd8;
                disp_count <= disp_count + 1;
                retire_q.push_back({exp_stale[0], exp_stale[1]});
                if (fl_model.size() > 0) begin
                    void'(fl_model.pop_front());
                end
            end
            fl_head_exp <= (fl_model.size() > 0) ? fl_model[0] : '0;
        end
    end

    // Reset, memory, back-pressure and retire driven on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            reset_cycles++;
            if (reset_cycles == 3) begin
                reset = 1'b0;
            end
        end else begin
            imem_resp = 1'b0;
            if (imem_rmask == 4'hf) begin
                // 0 to 3 idle cycles per request
                if (wait_left < 0) begin
                    wait_left = int'(take_bits(2));
                end
                if (wait_left == 0) begin
                    if (((imem_addr - `RESET_PC) >> 2) >= MEM_WORDS) begin
                        errors++;
                        $display("Fetch address %h lies outside the memory model", imem_addr);
                    end
                    imem_resp  = 1'b1;
                    imem_rdata = word_at(imem_addr);
                    wait_left  = -1;
                end else begin
                    wait_left--;
                end
            end
            disp_ready   = (take_bits(2) != 32'd0);
            retire_valid = 1'b0;
            if (retire_en && retire_q.size() > 0 && take_bits(1) == 32'd1) begin
                retire_valid = 1'b1;
                {retire_preg[0], retire_preg[1]} = retire_q.pop_front();
            end
        end
    end

    for (genvar s = 0; s < `SS; s++) begin : g_slot_check
        pc_order: assert property (@(posedge clk) disable iff (reset)
            handshake |-> disp_pc[s] == exp_pc + 32'(4 * s))
            else report_mismatch("pc_order", s, 128'($sampled(exp_pc) + 32'(4 * s)),
                                 128'($sampled(disp_pc[s])));
        opc_class: assert property (@(posedge clk) disable iff (reset)
            handshake |-> disp_opcode[s] == exp_opc[s])
            else report_mismatch("opc_class", s, 128'($sampled(exp_opc[s])),
                                 128'($sampled(disp_opcode[s])));
        prd_alloc: assert property (@(posedge clk) disable iff (reset)
            handshake |-> disp_prd[s] == exp_prd[s])
            else report_mismatch("prd_alloc", s, 128'($sampled(exp_prd[s])),
                                 128'($sampled(disp_prd[s])));
        prs1_map: assert property (@(posedge clk) disable iff (reset)
            handshake |-> disp_prs1[s] == exp_prs1[s])
            else report_mismatch("prs1_map", s, 128'($sampled(exp_prs1[s])),
                                 128'($sampled(disp_prs1[s])));
        prs2_map: assert property (@(posedge clk) disable iff (reset)
            handshake |-> disp_prs2[s] == exp_prs2[s])
            else report_mismatch("prs2_map", s, 128'($sampled(exp_prs2[s])),
                                 128'($sampled(disp_prs2[s])));
        stale_map: assert property (@(posedge clk) disable iff (reset)
            handshake |-> disp_stale_prd[s] == exp_stale[s])
            else report_mismatch("stale_map", s, 128'($sampled(exp_stale[s])),
                                 128'($sampled(disp_stale_prd[s])));
        // A fresh register may not already hold a live mapping
        prd_unmapped: assert property (@(posedge clk) disable iff (reset)
            (handshake && exp_rd[s] != 5'd0) |-> !prd_mapped[s])
            else report_mismatch("prd_unmapped", s, 128'(0), 128'($sampled(disp_prd[s])));
    end

    disp_hold: assert property (@(posedge clk) disable iff (reset)
        (disp_valid && !disp_ready) |=> (disp_valid && disp_bus == held_bus))
        else report_mismatch("disp_hold", -1, 128'($sampled(held_bus)),
                             128'($sampled(disp_bus)));
    // Sixteen register pairs at most without a retire
    fl_limit: assert property (@(posedge clk) disable iff (reset)
        disp_valid |-> fl_free > 0)
        else report_mismatch("fl_limit", -1, 128'(0), 128'(1));
    fetch_stall: assert property (@(posedge clk) disable iff (reset)
        (iq_pairs >= `IQ_DEPTH) |-> imem_rmask == 4'h0)
        else report_mismatch("fetch_stall", -1, 128'(0), 128'($sampled(imem_rmask)));

    initial begin
        logic [31:0] hi;
        int          idx;
        bit          ok;
        // Register fields limited to x0..x7 so pairs often share registers
        for (int i = 0; i < MEM_WORDS; i++) begin
            idx          = int'(take_bits(4) % 32'd9);
            hi           = take_bits(19);
            mem_words[i] = {hi[18:12], 2'b00, hi[11:9], 2'b00, hi[8:6], hi[5:3],
                            2'b00, hi[2:0], MAJOR[idx]};
        end
        // Retire withheld until the free list runs dry
        wait_for_pairs(`FL_DEPTH, 2000, ok);
        if (!ok) begin
            $display("Timeout: fewer than %0d pairs dispatched before retire", `FL_DEPTH);
        end
        if (ok) begin
            wait_for_stall(500, ok);
            if (!ok) begin
                $display("Timeout: fetch never stalled on a full instruction queue");
            end
        end
        if (ok) begin
            // No dispatch possible here until retire resumes
            repeat (20) @(negedge clk);
            retire_en <= 1'b1;
            wait_for_pairs(48, 4000, ok);
            if (!ok) begin
                $display("Timeout: dispatch did not resume after retire");
            end
        end
        repeat (4) @(negedge clk);
        $display("errors %0d, pairs dispatched %0d, pairs retired %0d",
                 errors, disp_count, retire_count);
        if (ok && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

//--- two_inst_buff.sv
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module two_inst_buff (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  rv32i_types::decoded_inst_t decoded_inst,
    output rv32i_types::decoded_inst_t valid_inst [`SS],
    output logic                       valid_out
);
    import rv32i_types::*;

    decoded_inst_t slot0;
    logic          have_slot0;

    // Flips on every accepted word
    always_ff @(posedge clk) begin
        if (reset) begin
            have_slot0 <= 1'b0;
        end else if (valid) begin
            have_slot0 <= ~have_slot0;
        end
    end

    // Older half of the pair waits here
    always_ff @(posedge clk) begin
        if (valid && !have_slot0) begin
            slot0 <= decoded_inst;
        end
    end

    // Pair leaves in the cycle of its second word
    assign valid_inst[0] = slot0;
    assign valid_inst[1] = decoded_inst;
    assign valid_out     = valid & have_slot0;
endmodule
